// ==== rtl/trdb_pkg.sv ====
// shared types and field widths of the trace encoder
// every block refers to these by scoped names

package trdb_pkg;

    // class of a retired instruction as seen by the packetizer
    // no value is reserved for idle cycles because the event strobe covers that
    typedef enum logic [1:0] {
        EV_BRANCH    = 2'd0,
        EV_JUMP      = 2'd1,
        EV_EXCEPTION = 2'd2
    } trdb_event_e;

    // packet formats written into the output queue
    typedef enum logic [1:0] {
        PKT_BRANCH_FULL = 2'd0,
        PKT_ADDR        = 2'd1,
        PKT_EXCEPTION   = 2'd2
    } trdb_format_e;

    // the branch map holds one outcome bit per conditional branch
    localparam int unsigned MAP_BITS = 31;

    // the count has to reach MAP_BITS, so five bits are enough
    localparam int unsigned CNT_BITS = 5;

    // instruction addresses are full width since there is no compression
    localparam int unsigned ADDR_BITS = 32;

    // count at which a branch-only packet is forced out
    localparam int unsigned MAP_FULL = 31;

endpackage

// ==== rtl/trdb_if.sv ====
// internal buses of the encoder
// the event bus runs from capture to packetizer and the packet bus from packetizer to queue

interface trdb_event_if;

    // one strobe per classified instruction
    logic                              ev_valid;
    trdb_pkg::trdb_event_e             ev_kind;
    // branch outcome, only meaningful for EV_BRANCH
    logic                              ev_taken;
    // jump target or trapping address depending on the kind
    logic [trdb_pkg::ADDR_BITS-1:0]    ev_addr;

    modport source (output ev_valid, output ev_kind, output ev_taken, output ev_addr);
    modport sink   (input  ev_valid, input  ev_kind, input  ev_taken, input  ev_addr);

endinterface

interface trdb_packet_if;

    // a high strobe writes exactly one packet into the queue
    logic                              pkt_valid;
    trdb_pkg::trdb_format_e            pkt_format;
    logic [trdb_pkg::CNT_BITS-1:0]     pkt_branches;
    logic [trdb_pkg::MAP_BITS-1:0]     pkt_map;
    logic [trdb_pkg::ADDR_BITS-1:0]    pkt_addr;

    modport source (output pkt_valid, output pkt_format, output pkt_branches,
                    output pkt_map, output pkt_addr);
    modport sink   (input  pkt_valid, input  pkt_format, input  pkt_branches,
                    input  pkt_map, input  pkt_addr);

endinterface

// ==== rtl/trdb_instr_capture.sv ====
// registers the core's retirement report and classifies it into one event per cycle
// the event appears one cycle after the inputs are sampled

module trdb_instr_capture (
    input  logic                           clk_i,
    input  logic                           rst_ni,
    input  logic                           retire_i,
    input  logic                           is_branch_i,
    input  logic                           branch_taken_i,
    input  logic                           is_uninferable_i,
    input  logic                           exception_i,
    input  logic [trdb_pkg::ADDR_BITS-1:0] iaddr_i,
    trdb_event_if.source                   ev_o
);

    // qualifier flags decide whether an event exists, so they are cleared by reset
    logic retire_q;
    logic is_branch_q;
    logic is_uninferable_q;
    logic exception_q;

    // outcome and address only travel along with a valid event
    logic                           taken_q;
    logic [trdb_pkg::ADDR_BITS-1:0] iaddr_q;

    always_ff @(posedge clk_i, negedge rst_ni) begin
        if (!rst_ni) begin
            retire_q         <= 1'b0;
            is_branch_q      <= 1'b0;
            is_uninferable_q <= 1'b0;
            exception_q      <= 1'b0;
        end else begin
            retire_q         <= retire_i;
            is_branch_q      <= is_branch_i;
            is_uninferable_q <= is_uninferable_i;
            exception_q      <= exception_i;
        end
    end

    always_ff @(posedge clk_i) begin
        taken_q <= branch_taken_i;
        iaddr_q <= iaddr_i;
    end

    // priority is exception, then uninferable jump, then branch
    // a retired instruction with none of these flags is not traced
    always_comb begin
        ev_o.ev_valid = 1'b0;
        ev_o.ev_kind  = trdb_pkg::EV_BRANCH;
        if (retire_q) begin
            if (exception_q) begin
                ev_o.ev_valid = 1'b1;
                ev_o.ev_kind  = trdb_pkg::EV_EXCEPTION;
            end else if (is_uninferable_q) begin
                ev_o.ev_valid = 1'b1;
                ev_o.ev_kind  = trdb_pkg::EV_JUMP;
            end else if (is_branch_q) begin
                ev_o.ev_valid = 1'b1;
                ev_o.ev_kind  = trdb_pkg::EV_BRANCH;
            end
        end
    end

    assign ev_o.ev_taken = taken_q;
    assign ev_o.ev_addr  = iaddr_q;

endmodule

// ==== rtl/trdb_branch_map.sv ====
// keeps the ordered list of taken and not-taken branch outcomes
// outputs show the state after this cycle's update so a packet can copy it at once

module trdb_branch_map (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    input  logic                          valid_i,
    input  logic                          is_branch_i,
    input  logic                          flush_i,
    output logic [trdb_pkg::MAP_BITS-1:0] map_o,
    output logic [trdb_pkg::CNT_BITS-1:0] branches_o,
    output logic                          is_full_o,
    output logic                          is_empty_o
);

    logic [trdb_pkg::MAP_BITS-1:0] map_d;
    logic [trdb_pkg::MAP_BITS-1:0] map_q;
    logic [trdb_pkg::CNT_BITS-1:0] cnt_d;
    logic [trdb_pkg::CNT_BITS-1:0] cnt_q;

    // the count doubles as the write position of the next outcome
    always_comb begin
        map_d = map_q;
        cnt_d = cnt_q;
        if (flush_i) begin
            map_d = '0;
            cnt_d = '0;
            // a branch in the flush cycle starts the fresh map
            if (valid_i) begin
                map_d[0] = is_branch_i;
                cnt_d    = trdb_pkg::CNT_BITS'(1);
            end
        end else if (valid_i) begin
            // the packetizer flushes right after the map fills, so the index stays below 31
            map_d[cnt_q] = is_branch_i;
            cnt_d        = cnt_q + trdb_pkg::CNT_BITS'(1);
        end
    end

    always_ff @(posedge clk_i, negedge rst_ni) begin
        if (!rst_ni) begin
            map_q <= '0;
            cnt_q <= '0;
        end else begin
            map_q <= map_d;
            cnt_q <= cnt_d;
        end
    end

    // combinational path from the update to the outputs on purpose
    assign map_o      = map_d;
    assign branches_o = cnt_d;
    assign is_full_o  = (cnt_d == trdb_pkg::CNT_BITS'(trdb_pkg::MAP_FULL));
    assign is_empty_o = (cnt_d == '0);

endmodule

// ==== rtl/trdb_packetizer.sv ====
// turns classified events and the branch map state into trace packets
// packets are registered and the map is flushed one cycle after each packet decision

module trdb_packetizer (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    trdb_event_if.sink                    ev_i,
    input  logic [trdb_pkg::MAP_BITS-1:0] map_i,
    input  logic [trdb_pkg::CNT_BITS-1:0] branches_i,
    input  logic                          map_full_i,
    output logic                          map_valid_o,
    output logic                          map_taken_o,
    output logic                          map_flush_o,
    trdb_packet_if.source                 pkt_o
);

    logic                           emit;
    trdb_pkg::trdb_format_e         emit_format;
    logic [trdb_pkg::ADDR_BITS-1:0] emit_addr;
    logic                           flush_pending_q;

    // only conditional branches enter the map
    // jumps and exceptions leave it untouched until the flush
    assign map_valid_o = ev_i.ev_valid && (ev_i.ev_kind == trdb_pkg::EV_BRANCH);
    assign map_taken_o = ev_i.ev_taken;

    // packet decision for this cycle
    // a full map can only happen on a branch, so it never competes with the other two
    always_comb begin
        emit        = 1'b0;
        emit_format = trdb_pkg::PKT_BRANCH_FULL;
        emit_addr   = '0;
        if (ev_i.ev_valid && (ev_i.ev_kind == trdb_pkg::EV_EXCEPTION)) begin
            emit        = 1'b1;
            emit_format = trdb_pkg::PKT_EXCEPTION;
            emit_addr   = ev_i.ev_addr;
        end else if (ev_i.ev_valid && (ev_i.ev_kind == trdb_pkg::EV_JUMP)) begin
            emit        = 1'b1;
            emit_format = trdb_pkg::PKT_ADDR;
            emit_addr   = ev_i.ev_addr;
        end else if (map_full_i) begin
            // branch-only packets carry no address
            emit        = 1'b1;
            emit_format = trdb_pkg::PKT_BRANCH_FULL;
        end
    end

    // the strobe and the flush request are control state
    always_ff @(posedge clk_i, negedge rst_ni) begin
        if (!rst_ni) begin
            pkt_o.pkt_valid <= 1'b0;
            flush_pending_q <= 1'b0;
        end else begin
            pkt_o.pkt_valid <= emit;
            flush_pending_q <= emit;
        end
    end

    // packet fields copy the map after this cycle's update, so the branch that
    // filled the map is already part of it
    always_ff @(posedge clk_i) begin
        if (emit) begin
            pkt_o.pkt_format   <= emit_format;
            pkt_o.pkt_branches <= branches_i;
            pkt_o.pkt_map      <= map_i;
            pkt_o.pkt_addr     <= emit_addr;
        end
    end

    // the flush lines up with the packet strobe in the following cycle
    assign map_flush_o = flush_pending_q;

endmodule

// ==== rtl/trdb_packet_queue.sv ====
// circular packet buffer between the encoder and the external reader
// the head packet is shown as a level, pop_i removes it and a full queue drops new packets

module trdb_packet_queue #(
    parameter int unsigned DEPTH = 8
) (
    input  logic                           clk_i,
    input  logic                           rst_ni,
    trdb_packet_if.sink                    pkt_i,
    input  logic                           pop_i,
    output logic                           pkt_valid_o,
    output trdb_pkg::trdb_format_e         pkt_format_o,
    output logic [trdb_pkg::CNT_BITS-1:0]  pkt_branches_o,
    output logic [trdb_pkg::MAP_BITS-1:0]  pkt_map_o,
    output logic [trdb_pkg::ADDR_BITS-1:0] pkt_addr_o,
    output logic                           overflow_o
);

    localparam int unsigned PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CNT_W    = $clog2(DEPTH + 1);

    // one array per packet field keeps the read mux simple
    trdb_pkg::trdb_format_e         fmt_mem  [DEPTH];
    logic [trdb_pkg::CNT_BITS-1:0]  cnt_mem  [DEPTH];
    logic [trdb_pkg::MAP_BITS-1:0]  map_mem  [DEPTH];
    logic [trdb_pkg::ADDR_BITS-1:0] addr_mem [DEPTH];

    logic [PTR_BITS-1:0] wr_ptr_q;
    logic [PTR_BITS-1:0] rd_ptr_q;
    logic [CNT_W-1:0]    fill_q;
    logic                overflow_q;
    logic                full;
    logic                empty;
    logic                do_pop;
    logic                do_push;

    assign full   = (fill_q == CNT_W'(DEPTH));
    assign empty  = (fill_q == '0);
    // popping an empty queue has no effect
    assign do_pop = pop_i && !empty;
    // a pop in the same cycle frees the slot that the write needs
    assign do_push = pkt_i.pkt_valid && (!full || do_pop);

    // pointers wrap explicitly so depths that are not a power of two work
    always_ff @(posedge clk_i, negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q   <= '0;
            rd_ptr_q   <= '0;
            fill_q     <= '0;
            overflow_q <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            if (do_push && !do_pop) begin
                fill_q <= fill_q + 1'b1;
            end else if (do_pop && !do_push) begin
                fill_q <= fill_q - 1'b1;
            end
            // sticky until reset once any packet has been lost
            if (pkt_i.pkt_valid && !do_push) begin
                overflow_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            fmt_mem[wr_ptr_q]  <= pkt_i.pkt_format;
            cnt_mem[wr_ptr_q]  <= pkt_i.pkt_branches;
            map_mem[wr_ptr_q]  <= pkt_i.pkt_map;
            addr_mem[wr_ptr_q] <= pkt_i.pkt_addr;
        end
    end

    assign pkt_valid_o    = !empty;
    assign pkt_format_o   = fmt_mem[rd_ptr_q];
    assign pkt_branches_o = cnt_mem[rd_ptr_q];
    assign pkt_map_o      = map_mem[rd_ptr_q];
    assign pkt_addr_o     = addr_mem[rd_ptr_q];
    assign overflow_o     = overflow_q;

endmodule

// ==== rtl/trdb_encoder_top.sv ====
// top level of the instruction trace encoder with plain core-side and reader-side ports
// an instruction reaches the packet outputs three cycles after it retires

module trdb_encoder_top #(
    parameter int unsigned FIFO_DEPTH = 8
) (
    input  logic                           clk_i,
    input  logic                           rst_ni,
    input  logic                           retire_i,
    input  logic                           is_branch_i,
    input  logic                           branch_taken_i,
    input  logic                           is_uninferable_i,
    input  logic                           exception_i,
    input  logic [trdb_pkg::ADDR_BITS-1:0] iaddr_i,
    input  logic                           pop_i,
    output logic                           pkt_valid_o,
    output trdb_pkg::trdb_format_e         pkt_format_o,
    output logic [trdb_pkg::CNT_BITS-1:0]  pkt_branches_o,
    output logic [trdb_pkg::MAP_BITS-1:0]  pkt_map_o,
    output logic [trdb_pkg::ADDR_BITS-1:0] pkt_addr_o,
    output logic                           overflow_o
);

    trdb_event_if  ev_bus ();
    trdb_packet_if pkt_bus ();

    // point-to-point lines between packetizer and branch map
    logic                          map_valid;
    logic                          map_taken;
    logic                          map_flush;
    logic [trdb_pkg::MAP_BITS-1:0] map_bits;
    logic [trdb_pkg::CNT_BITS-1:0] map_count;
    logic                          map_full;
    // empty flag is observed by the bound checks for the idle case
    logic                          map_empty;

    trdb_instr_capture u_capture (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .retire_i         (retire_i),
        .is_branch_i      (is_branch_i),
        .branch_taken_i   (branch_taken_i),
        .is_uninferable_i (is_uninferable_i),
        .exception_i      (exception_i),
        .iaddr_i          (iaddr_i),
        .ev_o             (ev_bus.source)
    );

    trdb_branch_map u_branch_map (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .valid_i     (map_valid),
        .is_branch_i (map_taken),
        .flush_i     (map_flush),
        .map_o       (map_bits),
        .branches_o  (map_count),
        .is_full_o   (map_full),
        .is_empty_o  (map_empty)
    );

    trdb_packetizer u_packetizer (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .ev_i        (ev_bus.sink),
        .map_i       (map_bits),
        .branches_i  (map_count),
        .map_full_i  (map_full),
        .map_valid_o (map_valid),
        .map_taken_o (map_taken),
        .map_flush_o (map_flush),
        .pkt_o       (pkt_bus.source)
    );

    trdb_packet_queue #(
        .DEPTH (FIFO_DEPTH)
    ) u_queue (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .pkt_i          (pkt_bus.sink),
        .pop_i          (pop_i),
        .pkt_valid_o    (pkt_valid_o),
        .pkt_format_o   (pkt_format_o),
        .pkt_branches_o (pkt_branches_o),
        .pkt_map_o      (pkt_map_o),
        .pkt_addr_o     (pkt_addr_o),
        .overflow_o     (overflow_o)
    );

endmodule

// ==== verification/trdb_encoder_properties.sv ====
// concurrent checks on the encoder top level, attached to every instance with bind
// they watch the queue outputs and the link between packetizer and branch map

module trdb_encoder_properties (
    input logic                          clk_i,
    input logic                          rst_ni,
    input logic                          pkt_valid_i,
    input logic                          overflow_i,
    input logic [trdb_pkg::CNT_BITS-1:0] map_count_i,
    input logic                          map_flush_i,
    input logic                          map_empty_i
);

    // the first sampled cycle out of reset has an empty queue, no overflow and an empty map
    a_quiet_after_reset: assert property (@(posedge clk_i)
        $rose(rst_ni) |-> (!pkt_valid_i && !overflow_i && map_empty_i))
        else $error("queue output, overflow or branch map active right after reset");

    // a full map is flushed in the next cycle, so the count never runs past 31 entries
    a_full_map_flushed: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (map_count_i == trdb_pkg::CNT_BITS'(trdb_pkg::MAP_FULL)) |=> map_flush_i)
        else $error("full branch map not flushed in the next cycle");

    // a flush leaves at most the branch of the same cycle in the fresh map
    a_flush_restarts_map: assert property (@(posedge clk_i) disable iff (!rst_ni)
        map_flush_i |-> (map_count_i <= trdb_pkg::CNT_BITS'(1)))
        else $error("branch map kept old entries across a flush");

    // lost packets stay visible until the next reset
    a_overflow_sticky: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $past(overflow_i) |-> overflow_i)
        else $error("overflow flag cleared outside reset");

endmodule

bind trdb_encoder_top trdb_encoder_properties u_props (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .pkt_valid_i (pkt_valid_o),
    .overflow_i  (overflow_o),
    .map_count_i (map_count),
    .map_flush_i (map_flush),
    .map_empty_i (map_empty)
);

// ==== verification/tb_trdb_encoder.sv ====
// testbench for the trace encoder, replays the vector file and drains the packet queue
// run it from the project root so that the vector path resolves

module tb_trdb_encoder;

    // an instruction needs three cycles to reach the queue outputs, one more gives margin
    localparam int SETTLE_CYCLES = 4;
    localparam int WAIT_LIMIT    = 50;

    logic                           clk_i;
    logic                           rst_ni;
    logic                           retire_i;
    logic                           is_branch_i;
    logic                           branch_taken_i;
    logic                           is_uninferable_i;
    logic                           exception_i;
    logic [trdb_pkg::ADDR_BITS-1:0] iaddr_i;
    logic                           pop_i;
    logic                           pkt_valid_o;
    trdb_pkg::trdb_format_e         pkt_format_o;
    logic [trdb_pkg::CNT_BITS-1:0]  pkt_branches_o;
    logic [trdb_pkg::MAP_BITS-1:0]  pkt_map_o;
    logic [trdb_pkg::ADDR_BITS-1:0] pkt_addr_o;
    logic                           overflow_o;

    // expected packets packed as format, count, map and address
    logic [69:0] exp_q[$];
    int          errors;
    int          checks;
    int          test_errors;
    int          test_num;
    int          fd;
    int          nread;
    int          k;
    string       line;
    string       code;
    logic [31:0] f1, f2, f3, f4, f5, f6;

    trdb_encoder_top #(.FIFO_DEPTH(8)) dut0 (.*);

    initial clk_i = 1'b0;
    always #50 clk_i = ~clk_i;

    task automatic compare_value(input string name, input logic [63:0] exp_v,
                                 input logic [63:0] got_v);
        checks++;
        if (exp_v !== got_v) begin
            $display("FAIL %s expected %0h got %0h", name, exp_v, got_v);
            errors++;
            test_errors++;
        end
    endtask

    // one retirement report per rising edge
    task automatic drive_instr(input logic retire, input logic branch, input logic taken,
                               input logic uninf, input logic exc, input logic [31:0] addr);
        @(posedge clk_i);
        retire_i         <= retire;
        is_branch_i      <= branch;
        branch_taken_i   <= taken;
        is_uninferable_i <= uninf;
        exception_i      <= exc;
        iaddr_i          <= addr;
    endtask

    // a single-cycle pop strobe, then back to the sampling point
    task automatic pop_head();
        @(posedge clk_i);
        pop_i <= 1'b1;
        @(posedge clk_i);
        pop_i <= 1'b0;
        @(negedge clk_i);
    endtask

    task automatic drain_and_check(input logic expect_overflow);
        logic [69:0] exp_pkt;
        int          wait_cycles;
        drive_instr(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 32'd0);
        repeat (SETTLE_CYCLES) @(negedge clk_i);
        while (exp_q.size() > 0) begin
            exp_pkt     = exp_q.pop_front();
            wait_cycles = 0;
            while (!pkt_valid_o && wait_cycles < WAIT_LIMIT) begin
                @(negedge clk_i);
                wait_cycles++;
            end
            if (!pkt_valid_o) begin
                $display("timeout in test %0d, an expected packet never reached the queue",
                         test_num);
                errors++;
                test_errors++;
                exp_q.delete();
                return;
            end
            compare_value("pkt_format_o", 64'(exp_pkt[69:68]), 64'(pkt_format_o));
            compare_value("pkt_branches_o", 64'(exp_pkt[67:63]), 64'(pkt_branches_o));
            compare_value("pkt_map_o", 64'(exp_pkt[62:32]), 64'(pkt_map_o));
            compare_value("pkt_addr_o", 64'(exp_pkt[31:0]), 64'(pkt_addr_o));
            pop_head();
        end
        // anything still queued here is an extra packet
        compare_value("pkt_valid_o", 64'd0, 64'(pkt_valid_o));
        // popping the empty queue should change nothing at all
        pop_head();
        compare_value("pkt_valid_o", 64'd0, 64'(pkt_valid_o));
        compare_value("overflow_o", 64'(expect_overflow), 64'(overflow_o));
    endtask

    initial begin
        errors           = 0;
        checks           = 0;
        test_errors      = 0;
        test_num         = 0;
        rst_ni           = 1'b0;
        retire_i         = 1'b0;
        is_branch_i      = 1'b0;
        branch_taken_i   = 1'b0;
        is_uninferable_i = 1'b0;
        exception_i      = 1'b0;
        iaddr_i          = '0;
        pop_i            = 1'b0;
        repeat (4) @(posedge clk_i);
        rst_ni <= 1'b1;
        fd = $fopen("verification/trdb_encoder_vectors.txt", "r");
        if (fd == 0) begin
            $display("the vector file could not be opened");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                line  = "";
                code  = "";
                nread = $fgets(line, fd);
                nread = $sscanf(line, "%s %h %h %h %h %h %h", code, f1, f2, f3, f4, f5, f6);
                if (code == "b") begin
                    // outcome of the k-th branch is bit k of the pattern
                    for (k = 0; k < f1; k++) begin
                        drive_instr(1'b1, 1'b1, f2[k], 1'b0, 1'b0, 32'(k));
                    end
                end else if (code == "j") begin
                    for (k = 0; k < f1; k++) begin
                        drive_instr(1'b1, 1'b0, 1'b0, 1'b1, 1'b0, f2 + 32'(4 * k));
                    end
                end else if (code == "i") begin
                    drive_instr(f1[0], f2[0], f3[0], f4[0], f5[0], f6);
                end else if (code == "e") begin
                    for (k = 0; k < f1; k++) begin
                        exp_q.push_back({f2[1:0], f3[4:0], f4[30:0], f5 + 32'(4 * k)});
                    end
                end else if (code == "d") begin
                    test_num++;
                    drain_and_check(f1[0]);
                    if (test_errors == 0) begin
                        $display("test %0d passed", test_num);
                    end else begin
                        $display("test %0d failed with %0d errors", test_num, test_errors);
                    end
                    test_errors = 0;
                end else if (code.len() > 0 && code.getc(0) != "#") begin
                    $display("unknown line in the vector file: %s", line);
                    errors++;
                end
            end
            $fclose(fd);
        end
        $display("tests %0d, checks %0d, errors %0d", test_num, checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== verification/trdb_encoder_vectors.txt ====
# all fields hex. b count outcomes | j count first_target | i retire branch taken uninf exc addr
# e count format branches map first_addr (addr steps by 4) | d expected_overflow ends a test
# test 1: five branches then a jump
b 5 0000000d
j 1 00001000
e 1 1 05 0000000d 00001000
d 0
# test 2: full map, then one branch lands in the flushed map before a jump
b 1f 5a5a5a5a
b 1 00000001
j 1 00002000
e 1 0 1f 5a5a5a5a 00000000
e 1 1 01 00000001 00002000
d 0
# test 3: all flags at once is an exception and the outcome stays out of the map
b 2 00000003
i 1 1 1 1 1 00003000
j 1 00003100
e 1 2 02 00000003 00003000
e 1 1 00 00000000 00003100
d 0
# test 4: unretired and plain instructions leave no trace
b 1 00000001
i 0 1 1 0 0 00004000
i 0 0 0 1 1 00004004
i 1 0 1 0 0 00004008
b 1 00000000
j 1 00004100
e 1 1 02 00000001 00004100
d 0
# test 5: ten jumps into an eight deep queue
j a 00005000
e 8 1 00 00000000 00005000
d 1

// ==== project.f ====
rtl/trdb_pkg.sv
rtl/trdb_if.sv
rtl/trdb_instr_capture.sv
rtl/trdb_branch_map.sv
rtl/trdb_packetizer.sv
rtl/trdb_packet_queue.sv
rtl/trdb_encoder_top.sv
verification/trdb_encoder_properties.sv
verification/tb_trdb_encoder.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the encoder testbench with Verilator and runs it from the project root.
# Exit status is 0 only when the run log shows no failure.

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -f project.f \
    --top-module tb_trdb_encoder -o sim_trdb > "$BUILD_LOG" 2>&1
status=$?
if [ "$status" -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "build failed with status $status"
    exit 1
fi

./obj_dir/sim_trdb > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Something failed" "$SIM_LOG"; then
    exit 1
fi
if ! grep -q "Everything OK" "$SIM_LOG"; then
    echo "simulation ended without a result line"
    exit 1
fi
exit 0
